// ==== Makefile ====
TOP = ray_intersect_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== common/intersect_pkg.sv ====
`default_nettype none

package intersect_pkg;

  // ####################
  // number formats
  // ####################

  typedef logic signed [15:0] coord_t; // Q8.8.

  typedef coord_t [2:0] vec3_t; // x in slot 0.

  typedef logic signed [39:0] acc_t; // Q16.16 with headroom.

  typedef logic signed [79:0] disc_t;

  // object word, read by kind flag.
  typedef union packed {
    struct packed {
      logic [47:0] reserved;
      vec3_t       centre;
    } sph;
    struct packed {
      vec3_t axis;   // unit length.
      vec3_t point;
    } cyl;
  } obj_word_t;

  localparam int FRAC_BITS = 8;

  // ####################
  // radius constants
  // ####################

  localparam int SPHERE_RAD_SQ = 65536; // 1.0 in Q16.16.
  localparam int CYL_RAD_SQ    = 16384; // 0.25 in Q16.16.

  // ####################
  // depths and latency
  // ####################

  localparam int FIFO_DEPTH   = 8;
  localparam int OUT_CREDITS  = 4;
  localparam int PIPE_LATENCY = 4; // stage registers before the FIFO.

  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int OUT_CRED_W = $clog2(OUT_CREDITS + 1);

endpackage

`default_nettype wire

// ==== hw/coeff_stage.sv ====
`default_nettype none

module coeff_stage (
  input  wire                      aclk,
  input  wire                      arst_n,
  input  wire                      s2_valid,
  input  wire intersect_pkg::acc_t s2_dd,
  input  wire intersect_pkg::acc_t s2_od,
  input  wire intersect_pkg::acc_t s2_oo,
  input  wire intersect_pkg::acc_t s2_da,
  input  wire intersect_pkg::acc_t s2_oa,
  input  wire                      s2_is_cylinder,
  output logic                     s3_valid,
  output intersect_pkg::acc_t      s3_a,
  output intersect_pkg::acc_t      s3_half_b,
  output intersect_pkg::acc_t      s3_c,
  output logic                     s3_is_cylinder
);
  import intersect_pkg::*;

  acc_t rad_sq;

  // Q16.16 product back to Q16.16.
  function automatic acc_t qmul(input acc_t x, input acc_t y);
    disc_t p;
    p = disc_t'(x) * disc_t'(y);
    return acc_t'(p >>> (2 * FRAC_BITS));
  endfunction

  assign rad_sq = s2_is_cylinder ? acc_t'(CYL_RAD_SQ) : acc_t'(SPHERE_RAD_SQ);

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      s3_valid <= 1'b0;
    end else begin
      s3_valid <= s2_valid;
    end
  end

  // axis terms drop out for a sphere.
  always_ff @(posedge aclk) begin
    s3_a           <= s2_dd - qmul(s2_da, s2_da);
    s3_half_b      <= s2_od - qmul(s2_oa, s2_da);
    s3_c           <= s2_oo - qmul(s2_oa, s2_oa) - rad_sq;
    s3_is_cylinder <= s2_is_cylinder;
  end

endmodule

`default_nettype wire

// ==== hw/credit_buffer/result_credit_fifo.sv ====
`default_nettype none

module result_credit_fifo (
  input  wire                      aclk,
  input  wire                      arst_n,
  input  wire                      s4_valid,
  input  wire intersect_pkg::acc_t s4_a,
  input  wire intersect_pkg::acc_t s4_half_b,
  input  wire intersect_pkg::acc_t s4_c,
  input  wire                      s4_hit,
  input  wire                      s4_is_cylinder,
  output logic                     in_credit,
  output logic                     out_valid,
  output intersect_pkg::acc_t      out_a,
  output intersect_pkg::acc_t      out_half_b,
  output intersect_pkg::acc_t      out_c,
  output logic                     out_hit,
  output logic                     out_is_cylinder,
  input  wire                      out_credit
);
  import intersect_pkg::*;

  acc_t a_mem [FIFO_DEPTH];
  acc_t half_b_mem [FIFO_DEPTH];
  acc_t c_mem [FIFO_DEPTH];
  logic hit_mem [FIFO_DEPTH];
  logic cyl_mem [FIFO_DEPTH];

  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;
  logic [FIFO_CNT_W-1:0] in_cred_cnt;
  logic [OUT_CRED_W-1:0] out_cred_cnt;
  logic                  pop;

  // ####################
  // head and credits
  // ####################

  assign pop       = (count != '0) && (out_cred_cnt != '0);
  assign out_valid = pop;

  assign out_a           = a_mem[rd_ptr];
  assign out_half_b      = half_b_mem[rd_ptr];
  assign out_c           = c_mem[rd_ptr];
  assign out_hit         = hit_mem[rd_ptr];
  assign out_is_cylinder = cyl_mem[rd_ptr];

  // one credit per slot, covering items still in the PIPE_LATENCY stages too.
  assign in_credit = (in_cred_cnt != '0);

  // ####################
  // state
  // ####################

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      in_cred_cnt  <= FIFO_CNT_W'(FIFO_DEPTH);
      out_cred_cnt <= OUT_CRED_W'(OUT_CREDITS);
    end else begin
      if (s4_valid) begin
        wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two.
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count        <= count + FIFO_CNT_W'(s4_valid) - FIFO_CNT_W'(pop);
      in_cred_cnt  <= in_cred_cnt + FIFO_CNT_W'(pop) - FIFO_CNT_W'(in_credit);
      out_cred_cnt <= out_cred_cnt + OUT_CRED_W'(out_credit) - OUT_CRED_W'(pop);
    end
  end

  always_ff @(posedge aclk) begin
    if (s4_valid) begin
      a_mem[wr_ptr]      <= s4_a;
      half_b_mem[wr_ptr] <= s4_half_b;
      c_mem[wr_ptr]      <= s4_c;
      hit_mem[wr_ptr]    <= s4_hit;
      cyl_mem[wr_ptr]    <= s4_is_cylinder;
    end
  end

endmodule

`default_nettype wire

// ==== hw/dot_stage.sv ====
`default_nettype none

module dot_stage (
  input  wire                       aclk,
  input  wire                       arst_n,
  input  wire                       s1_valid,
  input  wire intersect_pkg::vec3_t s1_oc,
  input  wire intersect_pkg::vec3_t s1_dir,
  input  wire intersect_pkg::vec3_t s1_axis,
  input  wire                       s1_is_cylinder,
  output logic                      s2_valid,
  output intersect_pkg::acc_t       s2_dd,
  output intersect_pkg::acc_t       s2_od,
  output intersect_pkg::acc_t       s2_oo,
  output intersect_pkg::acc_t       s2_da,
  output intersect_pkg::acc_t       s2_oa,
  output logic                      s2_is_cylinder
);
  import intersect_pkg::*;

  // Q8.8 times Q8.8 lands in Q16.16 directly.
  function automatic acc_t dot3(input vec3_t u, input vec3_t v);
    acc_t sum;
    sum = '0;
    for (int i = 0; i < 3; i++) begin
      sum = sum + acc_t'(u[i]) * acc_t'(v[i]);
    end
    return sum;
  endfunction

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge aclk) begin
    s2_dd          <= dot3(s1_dir, s1_dir);
    s2_od          <= dot3(s1_oc, s1_dir);
    s2_oo          <= dot3(s1_oc, s1_oc);
    s2_da          <= dot3(s1_dir, s1_axis); // zero for spheres.
    s2_oa          <= dot3(s1_oc, s1_axis);
    s2_is_cylinder <= s1_is_cylinder;
  end

endmodule

`default_nettype wire

// ==== hw/hit_stage.sv ====
`default_nettype none

module hit_stage (
  input  wire                      aclk,
  input  wire                      arst_n,
  input  wire                      s3_valid,
  input  wire intersect_pkg::acc_t s3_a,
  input  wire intersect_pkg::acc_t s3_half_b,
  input  wire intersect_pkg::acc_t s3_c,
  input  wire                      s3_is_cylinder,
  output logic                     s4_valid,
  output intersect_pkg::acc_t      s4_a,
  output intersect_pkg::acc_t      s4_half_b,
  output intersect_pkg::acc_t      s4_c,
  output logic                     s4_hit,
  output logic                     s4_is_cylinder
);
  import intersect_pkg::*;

  disc_t disc;

  // full width, no rescale.
  assign disc = disc_t'(s3_half_b) * disc_t'(s3_half_b) - disc_t'(s3_a) * disc_t'(s3_c);

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      s4_valid <= 1'b0;
    end else begin
      s4_valid <= s3_valid;
    end
  end

  always_ff @(posedge aclk) begin
    s4_a           <= s3_a;
    s4_half_b      <= s3_half_b;
    s4_c           <= s3_c;
    s4_hit         <= ~disc[$bits(disc_t)-1]; // disc >= 0.
    s4_is_cylinder <= s3_is_cylinder;
  end

endmodule

`default_nettype wire

// ==== hw/ray_intersect_top.sv ====
`default_nettype none

module ray_intersect_top (
  input  wire                           aclk,
  input  wire                           arst_n,
  input  wire                           in_valid,
  input  wire intersect_pkg::vec3_t     ray_origin,
  input  wire intersect_pkg::vec3_t     ray_dir,
  input  wire intersect_pkg::obj_word_t obj_word,
  input  wire                           is_cylinder,
  output logic                          in_credit,
  output logic                          out_valid,
  output intersect_pkg::acc_t           out_a,
  output intersect_pkg::acc_t           out_half_b,
  output intersect_pkg::acc_t           out_c,
  output logic                          out_hit,
  output logic                          out_is_cylinder,
  input  wire                           out_credit
);
  import intersect_pkg::*;

  wire        s1_valid;
  wire vec3_t s1_oc;
  wire vec3_t s1_dir;
  wire vec3_t s1_axis;
  wire        s1_is_cylinder;

  wire        s2_valid;
  wire acc_t  s2_dd;
  wire acc_t  s2_od;
  wire acc_t  s2_oo;
  wire acc_t  s2_da;
  wire acc_t  s2_oa;
  wire        s2_is_cylinder;

  wire        s3_valid;
  wire acc_t  s3_a;
  wire acc_t  s3_half_b;
  wire acc_t  s3_c;
  wire        s3_is_cylinder;

  wire        s4_valid;
  wire acc_t  s4_a;
  wire acc_t  s4_half_b;
  wire acc_t  s4_c;
  wire        s4_hit;
  wire        s4_is_cylinder;

  ray_obj_decode u_decode (
    .aclk, .arst_n, .in_valid, .ray_origin, .ray_dir, .obj_word, .is_cylinder,
    .s1_valid, .s1_oc, .s1_dir, .s1_axis, .s1_is_cylinder
  );

  dot_stage u_dot (
    .aclk, .arst_n, .s1_valid, .s1_oc, .s1_dir, .s1_axis, .s1_is_cylinder,
    .s2_valid, .s2_dd, .s2_od, .s2_oo, .s2_da, .s2_oa, .s2_is_cylinder
  );

  coeff_stage u_coeff (
    .aclk, .arst_n, .s2_valid, .s2_dd, .s2_od, .s2_oo, .s2_da, .s2_oa, .s2_is_cylinder,
    .s3_valid, .s3_a, .s3_half_b, .s3_c, .s3_is_cylinder
  );

  hit_stage u_hit (
    .aclk, .arst_n, .s3_valid, .s3_a, .s3_half_b, .s3_c, .s3_is_cylinder,
    .s4_valid, .s4_a, .s4_half_b, .s4_c, .s4_hit, .s4_is_cylinder
  );

  // results wait here for output credits.
  result_credit_fifo u_fifo (
    .aclk, .arst_n, .s4_valid, .s4_a, .s4_half_b, .s4_c, .s4_hit, .s4_is_cylinder,
    .in_credit, .out_valid, .out_a, .out_half_b, .out_c, .out_hit, .out_is_cylinder,
    .out_credit
  );

endmodule

`default_nettype wire

// ==== hw/ray_obj_decode.sv ====
`default_nettype none

module ray_obj_decode (
  input  wire                       aclk,
  input  wire                       arst_n,
  input  wire                       in_valid,
  input  wire intersect_pkg::vec3_t ray_origin,
  input  wire intersect_pkg::vec3_t ray_dir,
  input  wire intersect_pkg::obj_word_t obj_word,
  input  wire                       is_cylinder,
  output logic                      s1_valid,
  output intersect_pkg::vec3_t      s1_oc,
  output intersect_pkg::vec3_t      s1_dir,
  output intersect_pkg::vec3_t      s1_axis,
  output logic                      s1_is_cylinder
);
  import intersect_pkg::*;

  vec3_t base;
  vec3_t axis;

  // sphere has no axis.
  always_comb begin
    if (is_cylinder) begin
      base = obj_word.cyl.point;
      axis = obj_word.cyl.axis;
    end else begin
      base = obj_word.sph.centre;
      axis = '0;
    end
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  always_ff @(posedge aclk) begin
    for (int i = 0; i < 3; i++) begin
      s1_oc[i] <= ray_origin[i] - base[i]; // origin minus centre.
    end
    s1_dir         <= ray_dir;
    s1_axis        <= axis;
    s1_is_cylinder <= is_cylinder;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
common/intersect_pkg.sv
hw/ray_obj_decode.sv
hw/dot_stage.sv
hw/coeff_stage.sv
hw/hit_stage.sv
hw/credit_buffer/result_credit_fifo.sv
hw/ray_intersect_top.sv
verif/tb_clock.sv
verif/ray_intersect_tb.sv

// ==== verif/ray_intersect_tb.sv ====
`default_nettype none

module ray_intersect_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import intersect_pkg::*;

  typedef logic signed [127:0] wide_t;
  typedef struct packed {
    wide_t a;
    wide_t half_b;
    wide_t c;
    logic  hit;
    logic  cyl;
  } result_t;

  localparam int ONE_Q88 = 256;
  localparam int ONE_Q16 = 65536;
  localparam int IDLE_LATENCY = PIPE_LATENCY + 1; // stages plus the FIFO write.
  localparam int CREDIT_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT = 500;
  localparam int CREDIT_NOW = 0;
  localparam int CREDIT_HOLD = 1;
  localparam int CREDIT_RANDOM = 2;

  logic      aclk;
  logic      arst_n;
  logic      in_valid;
  vec3_t     ray_origin;
  vec3_t     ray_dir;
  obj_word_t obj_word;
  logic      is_cylinder;
  logic      in_credit;
  logic      out_valid;
  acc_t      out_a;
  acc_t      out_half_b;
  acc_t      out_c;
  logic      out_hit;
  logic      out_is_cylinder;
  logic      out_credit;

  result_t exp_q[$];
  int cycle = 0;
  int src_credits = 0;
  int in_credit_total = 0;
  int first_credit_cycle = 0;
  int last_credit_cycle = 0;
  int sent_total = 0;
  int out_total = 0;
  int credits_returned = 0;
  int consumer_held = 0;
  int credit_mode = CREDIT_NOW;
  int last_in_cycle = 0;
  int last_out_cycle = 0;
  acc_t last_out_a;

  tb_clock u_clock (.aclk(aclk));

  ray_intersect_top u_ray_intersect_top (
    .aclk, .arst_n, .in_valid, .ray_origin, .ray_dir, .obj_word, .is_cylinder,
    .in_credit, .out_valid, .out_a, .out_half_b, .out_c, .out_hit, .out_is_cylinder,
    .out_credit
  );

  // ####################
  // reporting
  // ####################

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input wide_t expected, input wide_t actual);
    report_failure($sformatf("Error at %0t: %s expected %0d, got %0d",
                             $time, name, expected, actual));
  endtask

  // ####################
  // reference model
  // ####################

  function automatic result_t model_result(input vec3_t origin, input vec3_t dir,
                                           input vec3_t base, input vec3_t axis, input logic cyl);
    wide_t dd;
    wide_t od;
    wide_t oo;
    wide_t da;
    wide_t oa;
    wide_t disc;
    wide_t oc [3];
    wide_t ax [3];
    result_t r;
    dd = 0;
    od = 0;
    oo = 0;
    da = 0;
    oa = 0;
    for (int i = 0; i < 3; i++) begin
      oc[i] = wide_t'(origin[i]) - wide_t'(base[i]);
      ax[i] = cyl ? wide_t'(axis[i]) : wide_t'(0); // a sphere has no axis.
      dd += wide_t'(dir[i]) * wide_t'(dir[i]);
      od += oc[i] * wide_t'(dir[i]);
      oo += oc[i] * oc[i];
      da += wide_t'(dir[i]) * ax[i];
      oa += oc[i] * ax[i];
    end
    r.a = dd - ((da * da) >>> 16);
    r.half_b = od - ((oa * da) >>> 16);
    r.c = oo - ((oa * oa) >>> 16) - (cyl ? wide_t'(ONE_Q16 / 4) : wide_t'(ONE_Q16));
    disc = r.half_b * r.half_b - r.a * r.c;
    r.hit = (disc >= 0);
    r.cyl = cyl;
    return r;
  endfunction

  task automatic check_result(input result_t exp);
    assert (wide_t'(out_a) == exp.a) else report_mismatch("out_a", exp.a, out_a);
    assert (wide_t'(out_half_b) == exp.half_b)
      else report_mismatch("out_half_b", exp.half_b, out_half_b);
    assert (wide_t'(out_c) == exp.c) else report_mismatch("out_c", exp.c, out_c);
    assert (out_hit == exp.hit) else report_mismatch("out_hit", exp.hit, out_hit);
    assert (out_is_cylinder == exp.cyl)
      else report_mismatch("out_is_cylinder", exp.cyl, out_is_cylinder);
  endtask

  // ####################
  // monitor and consumer
  // ####################

  // sampled mid-cycle, so each value is the one the next rising edge sees.
  always @(negedge aclk) begin : monitor
    if (arst_n) begin
      cycle++;
      if (in_valid) begin
        exp_q.push_back(model_result(ray_origin, ray_dir, vec3_t'(obj_word[47:0]),
                                     vec3_t'(obj_word[95:48]), is_cylinder));
        src_credits--;
        sent_total++;
        last_in_cycle = cycle;
      end
      if (in_credit) begin
        if (in_credit_total == 0) first_credit_cycle = cycle;
        last_credit_cycle = cycle;
        in_credit_total++;
        src_credits++;
      end
      if (out_valid) begin
        assert (out_total < OUT_CREDITS + credits_returned)
          else report_failure("out_valid raised with no output credit left");
        assert (exp_q.size() > 0) else report_failure("result delivered with none expected");
        check_result(exp_q.pop_front());
        out_total++;
        consumer_held++;
        last_out_cycle = cycle;
        last_out_a = out_a;
      end
      if (out_credit) credits_returned++;
    end
  end

  always @(posedge aclk) begin : consumer
    logic give;
    give = arst_n && (consumer_held > 0) &&
           ((credit_mode == CREDIT_NOW) ||
            (credit_mode == CREDIT_RANDOM && $urandom_range(1, 0) == 1));
    if (give) consumer_held--;
    #1;
    out_credit = give;
  end

  reset_quiet: assert property (@(posedge aclk) !arst_n |-> !out_valid)
    else report_failure("out_valid raised during reset");
  credit_at_release: assert property (@(posedge aclk) $rose(arst_n) |-> in_credit)
    else report_failure("in_credit low right after reset");

  // ####################
  // stimulus
  // ####################

  function automatic vec3_t vec(input int x, input int y, input int z);
    vec3_t v;
    v[0] = coord_t'(x);
    v[1] = coord_t'(y);
    v[2] = coord_t'(z);
    return v;
  endfunction

  function automatic vec3_t random_vec();
    return vec(int'($urandom_range(4095, 0)) - 2048, int'($urandom_range(4095, 0)) - 2048,
               int'($urandom_range(4095, 0)) - 2048); // within +-8.0.
  endfunction

  task automatic send_item(input vec3_t origin, input vec3_t dir, input logic [95:0] obj,
                           input logic cyl);
    int waited;
    waited = 0;
    while (src_credits == 0) begin
      @(posedge aclk);
      #1;
      waited++;
      if (waited > CREDIT_TIMEOUT) report_failure("no input credit arrived in time");
    end
    in_valid = 1'b1;
    ray_origin = origin;
    ray_dir = dir;
    obj_word = obj;
    is_cylinder = cyl;
    @(posedge aclk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic send_random(input logic cyl);
    vec3_t o;
    vec3_t d;
    vec3_t p;
    vec3_t ax;
    int sel;
    o = random_vec();
    d = random_vec();
    p = random_vec();
    if (cyl) begin
      sel = $urandom_range(2, 0);
      ax = '0;
      ax[sel] = ($urandom_range(1, 0) == 1) ? coord_t'(ONE_Q88) : coord_t'(-ONE_Q88);
    end else begin
      ax = random_vec(); // reserved half is ignored.
    end
    send_item(o, d, {ax, p}, cyl);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 || consumer_held != 0) begin
      @(posedge aclk);
      #1;
      waited++;
      if (waited > DRAIN_TIMEOUT) report_failure("results did not drain in time");
    end
    repeat (3) @(posedge aclk);
    #1;
  endtask

  initial begin
    int out0;
    void'($urandom(32'h8050181d));
    arst_n = 1'b0;
    in_valid = 1'b0;
    ray_origin = '0;
    ray_dir = '0;
    obj_word = '0;
    is_cylinder = 1'b0;
    out_credit = 1'b0;
    repeat (4) @(posedge aclk);
    #1;
    arst_n = 1'b1;

    // idle after reset with credits only.
    repeat (12) @(posedge aclk);
    #1;
    assert (in_credit_total == FIFO_DEPTH)
      else report_mismatch("in_credit pulses", FIFO_DEPTH, in_credit_total);
    assert (last_credit_cycle - first_credit_cycle == FIFO_DEPTH - 1)
      else report_failure("in_credit pulses after reset were not consecutive");

    send_item(vec(0, 0, 0), vec(0, 0, ONE_Q88), {48'h0, vec(0, 0, 1280)}, 1'b0);
    drain();
    assert (last_out_cycle - last_in_cycle == IDLE_LATENCY)
      else report_mismatch("out_valid latency", IDLE_LATENCY, last_out_cycle - last_in_cycle);

    // sphere miss, inside start, oblique ray.
    send_item(vec(0, 0, 0), vec(0, 0, ONE_Q88), {48'h0, vec(768, 0, 1280)}, 1'b0);
    send_item(vec(64, 0, 1280), vec(ONE_Q88, 0, 0), {48'hdead_beef_cafe, vec(0, 0, 1280)}, 1'b0);
    send_item(vec(-512, 0, 0), vec(181, 181, 0), {48'h0, vec(0, 512, 0)}, 1'b0);
    repeat (20) send_random(1'b0);
    drain();

    // cylinders along z, x and y.
    send_item(vec(512, 0, 0), vec(-ONE_Q88, 0, 0), {vec(0, 0, ONE_Q88), vec(0, 0, 0)}, 1'b1);
    send_item(vec(0, 512, 0), vec(0, -ONE_Q88, 0), {vec(ONE_Q88, 0, 0), vec(0, 0, 0)}, 1'b1);
    send_item(vec(1024, 0, -768), vec(0, 0, ONE_Q88), {vec(0, ONE_Q88, 0), vec(0, 0, 0)}, 1'b1);
    send_item(vec(0, 0, -768), vec(0, 0, ONE_Q88), {vec(0, -ONE_Q88, 0), vec(0, 0, 0)}, 1'b1);
    send_item(vec(0, 512, 0), vec(ONE_Q88, 0, 0), {vec(ONE_Q88, 0, 0), vec(0, 0, 0)}, 1'b1);
    drain();
    assert (last_out_a == '0) else report_mismatch("out_a", 0, last_out_a);
    repeat (20) send_random(1'b1);
    drain();

    // ####################
    // back-pressure
    // ####################
    out0 = out_total;
    credit_mode = CREDIT_HOLD;
    fork
      begin
        for (int i = 0; i < 14; i++) send_random(i[0]);
      end
      begin
        repeat (40) @(posedge aclk);
        #1;
        assert (out_total - out0 == OUT_CREDITS)
          else report_mismatch("out_valid pulses", OUT_CREDITS, out_total - out0);
        assert (exp_q.size() == FIFO_DEPTH)
          else report_mismatch("results held", FIFO_DEPTH, exp_q.size());
        assert (src_credits == 0) else report_mismatch("source credits", 0, src_credits);
        credit_mode = CREDIT_NOW;
      end
    join
    drain();

    // random soak.
    credit_mode = CREDIT_RANDOM;
    for (int i = 0; i < 300; i++) send_random($urandom_range(1, 0) == 1);
    credit_mode = CREDIT_NOW;
    drain();
    assert (in_credit_total == FIFO_DEPTH + out_total)
      else report_mismatch("in_credit pulses", FIFO_DEPTH + out_total, in_credit_total);

    if (exp_q.size() == 0 && out_total == sent_total) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      report_failure("results lost or left over at the end of the run");
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`default_nettype none

module tb_clock (
  output logic aclk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    aclk = 1'b0;
  end

  always #5 aclk = ~aclk; // 10 ns period.

endmodule

`default_nettype wire
